/* common/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data path, address and axi data width
`define DATA_W 32

// one strobe bit per byte lane
`define STRB_W 4

// axi response field
`define RESP_W 2
`define AXI_RESP_OKAY 2'b00

// rv32i opcodes
`define OPC_LOAD 7'b0000011
`define OPC_STORE 7'b0100011

// data memory depth in words, power of two
`define DMEM_WORDS 1024

`endif

/* common/rv_mem_pkg.sv */
`default_nettype none

`include "lsu_config.svh"

package rv_mem_pkg;

    typedef logic [`DATA_W-1:0] word_t;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
    } inst_t;

    // funct3 access width codes
    localparam logic [2:0] F3_B = 3'b000;
    localparam logic [2:0] F3_H = 3'b001;
    localparam logic [2:0] F3_W = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

endpackage

`default_nettype wire

/* design/axi_lite_dmem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module axi_lite_dmem
    import rv_mem_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,
    // AR
    input word_t araddr,
    input wire logic arvalid,
    output logic arready,
    // R
    output word_t rdata,
    output logic [`RESP_W-1:0] rresp,
    output logic rvalid,
    input wire logic rready,
    // AW
    input word_t awaddr,
    input wire logic awvalid,
    output logic awready,
    // W
    input word_t wdata,
    input wire logic [`STRB_W-1:0] wstrb,
    input wire logic wvalid,
    output logic wready,
    // B
    output logic [`RESP_W-1:0] bresp,
    output logic bvalid,
    input wire logic bready
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    word_t mem [`DMEM_WORDS];
    logic idle;
    logic rd_fire;
    logic wr_fire;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // word index, upper address bits wrap
    assign rd_idx = araddr[IDX_W+1:2];
    assign wr_idx = awaddr[IDX_W+1:2];

    // no new request until the pending response has gone
    assign idle = !rvalid && !bvalid;
    assign arready = idle;
    assign awready = idle;
    assign wready = idle;

    assign rd_fire = arvalid && arready;
    assign wr_fire = awvalid && awready && wvalid && wready;

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= mem[rd_idx];
        end
        if (wr_fire) begin
            for (int b = 0; b < `STRB_W; b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    assign rresp = `AXI_RESP_OKAY;
    assign bresp = `AXI_RESP_OKAY;

endmodule

`default_nettype wire

/* design/mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module mem_stage_top
    import rv_mem_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,
    input inst_t inst,
    input word_t raddr,
    input word_t waddr,
    input word_t ex_wdata,
    input wire logic wen,
    input wire logic req,
    input wire logic prev_valid,
    input wire logic next_ready,
    output logic this_ready,
    output logic this_valid,
    output word_t lsu_rdata,
    output logic lsu_pipe_ctrl_valid
);

    word_t araddr;
    logic arvalid;
    logic arready;
    word_t rdata;
    logic [`RESP_W-1:0] rresp;
    logic rvalid;
    logic rready;
    word_t awaddr;
    logic awvalid;
    logic awready;
    word_t wdata;
    logic [`STRB_W-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [`RESP_W-1:0] bresp;
    logic bvalid;
    logic bready;

    lsu u_lsu (
        .clk(clk),
        .rst_n(rst_n),
        .inst(inst),
        .raddr(raddr),
        .waddr(waddr),
        .ex_wdata(ex_wdata),
        .wen(wen),
        .req(req),
        .prev_valid(prev_valid),
        .next_ready(next_ready),
        .this_ready(this_ready),
        .this_valid(this_valid),
        .lsu_pipe_ctrl_valid(lsu_pipe_ctrl_valid),
        .lsu_rdata(lsu_rdata),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready)
    );

    axi_lite_dmem u_dmem (
        .clk(clk),
        .rst_n(rst_n),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wstrb(wstrb),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready)
    );

endmodule

`default_nettype wire

/* lsu/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu
    import rv_mem_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,
    input inst_t inst,
    input word_t raddr,
    input word_t waddr,
    input word_t ex_wdata,
    input wire logic wen,
    input wire logic req,
    input wire logic prev_valid,
    input wire logic next_ready,
    output logic this_ready,
    output logic this_valid,
    output logic lsu_pipe_ctrl_valid,
    output word_t lsu_rdata,
    // AR
    output word_t araddr,
    output logic arvalid,
    input wire logic arready,
    // R
    input word_t rdata,
    input wire logic [`RESP_W-1:0] rresp,
    input wire logic rvalid,
    output logic rready,
    // AW
    output word_t awaddr,
    output logic awvalid,
    input wire logic awready,
    // W
    output word_t wdata,
    output logic [`STRB_W-1:0] wstrb,
    output logic wvalid,
    input wire logic wready,
    // B
    input wire logic [`RESP_W-1:0] bresp,
    input wire logic bvalid,
    output logic bready
);

    logic busy;
    logic pass_through;

    // one transaction in flight, from address transfer to response transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if ((arvalid && arready) || (awvalid && awready && wvalid && wready)) begin
            busy <= 1'b1;
        end else if ((rvalid && rready) || (bvalid && bready)) begin
            busy <= 1'b0;
        end
    end

    lsu_load_align u_load_align (
        .inst(inst),
        .byte_off(raddr[1:0]),
        .rdata(rdata),
        .load_data(lsu_rdata)
    );

    lsu_store_align u_store_align (
        .inst(inst),
        .byte_off(waddr[1:0]),
        .store_data(ex_wdata),
        .wdata(wdata),
        .wstrb(wstrb)
    );

    assign araddr = raddr;
    assign arvalid = req && prev_valid && !busy;
    assign rready = next_ready;

    // aw and w go out together
    assign awaddr = waddr;
    assign awvalid = wen && prev_valid && !busy;
    assign wvalid = wen && prev_valid && !busy;
    assign bready = next_ready;

    // neither load nor store, no memory access
    assign pass_through = !req && !wen && prev_valid;

    assign this_valid = (req && rvalid) || (wen && bvalid) || pass_through;
    assign this_ready = !prev_valid || (this_valid && next_ready);

    // stage occupied, seen by the stall controller
    assign lsu_pipe_ctrl_valid = prev_valid || busy || this_valid;

endmodule

`default_nettype wire

/* lsu/lsu_load_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_load_align
    import rv_mem_pkg::*;
(
    input inst_t inst,
    input wire logic [1:0] byte_off,
    input word_t rdata,
    output word_t load_data
);

    word_t shifted;

    // addressed byte moves down to lane 0
    assign shifted = rdata >> {byte_off, 3'b000};

    always_comb begin
        load_data = shifted;
        if (inst.i_fmt.opcode == `OPC_LOAD) begin
            case (inst.i_fmt.funct3)
                F3_B: begin
                    load_data = {{(`DATA_W-8){shifted[7]}}, shifted[7:0]};
                end
                F3_H: begin
                    load_data = {{(`DATA_W-16){shifted[15]}}, shifted[15:0]};
                end
                F3_BU: begin
                    load_data = {{(`DATA_W-8){1'b0}}, shifted[7:0]};
                end
                F3_HU: begin
                    load_data = {{(`DATA_W-16){1'b0}}, shifted[15:0]};
                end
                default: begin
                    // F3_W and reserved codes take the whole word
                    load_data = shifted;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* lsu/lsu_store_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_store_align
    import rv_mem_pkg::*;
(
    input inst_t inst,
    input wire logic [1:0] byte_off,
    input word_t store_data,
    output word_t wdata,
    output logic [`STRB_W-1:0] wstrb
);

    logic [`STRB_W-1:0] base_strb;

    // data moves up to the addressed lane
    assign wdata = store_data << {byte_off, 3'b000};

    always_comb begin
        base_strb = '0;
        if (inst.s_fmt.opcode == `OPC_STORE) begin
            case (inst.s_fmt.funct3)
                F3_B: base_strb = `STRB_W'(4'b0001);
                F3_H: base_strb = `STRB_W'(4'b0011);
                F3_W: base_strb = `STRB_W'(4'b1111);
                default: base_strb = '0;
            endcase
        end
    end

    assign wstrb = base_strb << byte_off;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -f sources.f --top-module tb_mem_stage -o tb_mem_stage \
    && ./obj_dir/tb_mem_stage | tee /dev/stderr | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/mem_stage_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_asserts
    import rv_mem_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,
    input wire word_t araddr,
    input wire logic arvalid,
    input wire logic arready,
    input wire word_t rdata,
    input wire logic rvalid,
    input wire logic rready,
    input wire word_t awaddr,
    input wire logic awvalid,
    input wire logic awready,
    input wire logic bvalid,
    input wire logic bready,
    input wire logic prev_valid,
    input wire logic this_valid
);

    int fail_count = 0;

    // valid and payload held until the transfer
    ar_held: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid or araddr changed before the AR transfer");
            fail_count++;
        end

    r_held: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $error("rvalid or rdata changed before the R transfer");
            fail_count++;
        end

    aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("awvalid or awaddr changed before the AW transfer");
            fail_count++;
        end

    b_held: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before the B transfer");
            fail_count++;
        end

    // only one address channel at a time
    one_request: assert property (@(posedge clk) disable iff (!rst_n)
        !(arvalid && awvalid))
        else begin
            $error("arvalid and awvalid high together");
            fail_count++;
        end

    valid_needs_input: assert property (@(posedge clk) disable iff (!rst_n)
        this_valid |-> prev_valid)
        else begin
            $error("this_valid high without prev_valid");
            fail_count++;
        end

endmodule

bind mem_stage_top mem_stage_asserts u_asserts (.*);

`default_nettype wire

/* sim/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module tb_mem_stage
    import rv_mem_pkg::*;
;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_ROWS = 40;
    localparam int MEM_AW = $clog2(`DMEM_WORDS) + 2;
    localparam logic [1:0] K_LOAD = 2'd0;
    localparam logic [1:0] K_STORE = 2'd1;
    localparam logic [1:0] K_PASS = 2'd2;

    logic clk;
    logic rst_n;
    inst_t inst;
    word_t raddr;
    word_t waddr;
    word_t ex_wdata;
    logic wen;
    logic req;
    logic prev_valid;
    logic next_ready;
    logic this_ready;
    logic this_valid;
    word_t lsu_rdata;
    logic lsu_pipe_ctrl_valid;

    // stimulus table, expected load value filled from the byte model
    logic [1:0] tab_kind [MAX_ROWS];
    logic [2:0] tab_f3 [MAX_ROWS];
    word_t tab_addr [MAX_ROWS];
    word_t tab_data [MAX_ROWS];
    word_t tab_exp [MAX_ROWS];
    int n_rows;
    bit table_done;

    logic [7:0] model_mem [2**MEM_AW];

    mem_stage_top i_dut (
        .clk(clk),
        .rst_n(rst_n),
        .inst(inst),
        .raddr(raddr),
        .waddr(waddr),
        .ex_wdata(ex_wdata),
        .wen(wen),
        .req(req),
        .prev_valid(prev_valid),
        .next_ready(next_ready),
        .this_ready(this_ready),
        .this_valid(this_valid),
        .lsu_rdata(lsu_rdata),
        .lsu_pipe_ctrl_valid(lsu_pipe_ctrl_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s is %0b, expected %0b", what, got, exp));
        end
    endtask

    // handshake properties in the bound checker
    always @(i_dut.u_asserts.fail_count) begin
        if (i_dut.u_asserts.fail_count != 0) begin
            report_failure("a handshake assertion in the bound checker failed");
        end
    end

    // byte address inside the memory, upper bits wrap
    function automatic logic [MEM_AW-1:0] byte_index(input word_t addr, input int i);
        word_t a;
        a = addr + word_t'(i);
        return a[MEM_AW-1:0];
    endfunction

    task automatic model_store(input logic [2:0] f3, input word_t addr, input word_t data);
        int nbytes;
        nbytes = (f3 == F3_B) ? 1 : ((f3 == F3_H) ? 2 : 4);
        for (int i = 0; i < nbytes; i++) begin
            model_mem[byte_index(addr, i)] = data[8*i +: 8];
        end
    endtask

    function automatic word_t model_load(input logic [2:0] f3, input word_t addr);
        word_t raw;
        for (int i = 0; i < 4; i++) begin
            raw[8*i +: 8] = model_mem[byte_index(addr, i)];
        end
        case (f3)
            F3_B: return {{24{raw[7]}}, raw[7:0]};
            F3_H: return {{16{raw[15]}}, raw[15:0]};
            F3_BU: return {24'h0, raw[7:0]};
            F3_HU: return {16'h0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    task automatic add_row(input logic [1:0] kind, input logic [2:0] f3,
                           input word_t addr, input word_t data);
        tab_kind[n_rows] = kind;
        tab_f3[n_rows] = f3;
        tab_addr[n_rows] = addr;
        tab_data[n_rows] = data;
        tab_exp[n_rows] = '0;
        if (kind == K_STORE) begin
            model_store(f3, addr, data);
        end else if (kind == K_LOAD) begin
            tab_exp[n_rows] = model_load(f3, addr);
        end
        n_rows++;
    endtask

    function automatic inst_t make_inst(input logic [1:0] kind, input logic [2:0] f3);
        inst_t ins;
        ins = '0;
        if (kind == K_STORE) begin
            ins.s_fmt.opcode = `OPC_STORE;
            ins.s_fmt.funct3 = f3;
            ins.s_fmt.rs2 = 5'd7;
        end else begin
            // addi for a pass-through row
            ins.i_fmt.opcode = (kind == K_LOAD) ? `OPC_LOAD : 7'b0010011;
            ins.i_fmt.funct3 = f3;
            ins.i_fmt.rd = 5'd10;
        end
        return ins;
    endfunction

    task automatic run_row(input int r);
        int cyc;
        int lat;
        int stall;
        bit done;
        cyc = 0;
        done = 1'b0;
        lat = (tab_kind[r] == K_PASS) ? 0 : 1;
        stall = $urandom_range(3, 0);
        @(negedge clk);
        inst = make_inst(tab_kind[r], tab_f3[r]);
        raddr = tab_addr[r];
        waddr = tab_addr[r];
        ex_wdata = tab_data[r];
        req = (tab_kind[r] == K_LOAD);
        wen = (tab_kind[r] == K_STORE);
        prev_valid = 1'b1;
        while (!done) begin
            next_ready = (cyc >= lat + stall);
            #(CLK_PERIOD / 4);
            check_flag(this_valid, cyc >= lat, $sformatf("row %0d this_valid", r));
            check_flag(this_ready, (cyc >= lat) && next_ready,
                       $sformatf("row %0d this_ready", r));
            check_flag(lsu_pipe_ctrl_valid, 1'b1, $sformatf("row %0d lsu_pipe_ctrl_valid", r));
            if (tab_kind[r] == K_LOAD && cyc >= lat) begin
                check_word(lsu_rdata, tab_exp[r], $sformatf("row %0d lsu_rdata", r));
            end
            done = (cyc >= lat) && next_ready;
            if (!done) begin
                @(negedge clk);
                cyc++;
            end
        end
        // one idle cycle, the stage must look empty
        @(negedge clk);
        prev_valid = 1'b0;
        req = 1'b0;
        wen = 1'b0;
        next_ready = 1'b1;
        #(CLK_PERIOD / 4);
        check_flag(this_valid, 1'b0, $sformatf("row %0d idle this_valid", r));
        check_flag(this_ready, 1'b1, $sformatf("row %0d idle this_ready", r));
        check_flag(lsu_pipe_ctrl_valid, 1'b0, $sformatf("row %0d idle pipe_ctrl_valid", r));
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        inst = '0;
        raddr = '0;
        waddr = '0;
        ex_wdata = '0;
        wen = 1'b0;
        req = 1'b0;
        prev_valid = 1'b0;
        next_ready = 1'b1;
        n_rows = 0;
        void'($urandom(32'h08a4d3e3));

        add_row(K_STORE, F3_W, 32'h40, 32'hdeadbeef);
        add_row(K_LOAD, F3_W, 32'h40, '0);
        add_row(K_PASS, F3_W, '0, '0);
        add_row(K_STORE, F3_W, 32'h80, '0);
        add_row(K_STORE, F3_B, 32'h80, 32'h11223381);
        add_row(K_STORE, F3_B, 32'h81, 32'h0000007f);
        add_row(K_STORE, F3_B, 32'h82, 32'hffffffa5);
        add_row(K_STORE, F3_B, 32'h83, 32'h0000003c);
        add_row(K_LOAD, F3_W, 32'h80, '0);
        for (int off = 0; off < 4; off++) begin
            add_row(K_LOAD, F3_B, 32'h80 + word_t'(off), '0);
            add_row(K_LOAD, F3_BU, 32'h80 + word_t'(off), '0);
        end
        add_row(K_STORE, F3_W, 32'hc0, 32'h5a5a5a5a);
        add_row(K_STORE, F3_H, 32'hc0, 32'h12348001);
        add_row(K_STORE, F3_H, 32'hc2, 32'h00007ffe);
        add_row(K_LOAD, F3_W, 32'hc0, '0);
        for (int off = 0; off < 4; off += 2) begin
            add_row(K_LOAD, F3_H, 32'hc0 + word_t'(off), '0);
            add_row(K_LOAD, F3_HU, 32'hc0 + word_t'(off), '0);
        end
        // above the memory depth, lands on word 0x44
        add_row(K_STORE, F3_W, 32'h1044, 32'hcafef00d);
        add_row(K_LOAD, F3_W, 32'h44, '0);
        add_row(K_STORE, F3_B, 32'h41, 32'h00000055);
        add_row(K_LOAD, F3_W, 32'h40, '0);
        add_row(K_PASS, F3_B, '0, '0);
        table_done = 1'b1;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        #(CLK_PERIOD / 4);
        check_flag(lsu_pipe_ctrl_valid, 1'b0, "lsu_pipe_ctrl_valid after reset");
        check_flag(this_valid, 1'b0, "this_valid after reset");

        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        wait (table_done);
        #((n_rows * 8 + 10) * CLK_PERIOD);
        $display("watchdog expired before all table rows were applied");
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/rv_mem_pkg.sv
lsu/lsu_load_align.sv
lsu/lsu_store_align.sv
lsu/lsu.sv
design/axi_lite_dmem.sv
design/mem_stage_top.sv
sim/mem_stage_asserts.sv
sim/tb_mem_stage.sv
